// ==== rtl/pipe_ctrl_pkg.sv ====
// pipeline control package: address type, pc and jump selectors, stage status and control structs
package pipe_ctrl_pkg;

    // fetch address width
    localparam int ADDR_WIDTH = 40;

    // program address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // next pc source for the fetch stage
    typedef enum logic [1:0] {
        NEXT_PC_SEL_PC   = 2'b00,
        NEXT_PC_SEL_PC_4 = 2'b01,
        NEXT_PC_SEL_JUMP = 2'b10
    } next_pc_sel_t;

    // which jump target fetch loads
    typedef enum logic [1:0] {
        SEL_JUMP_DECODE = 2'b00,
        SEL_JUMP_COMMIT = 2'b01,
        SEL_JUMP_CSR    = 2'b10
    } jump_addr_sel_t;

    // decode stage status
    typedef struct packed {
        // unconditional jump decoded
        logic valid_jal;
        // csr op, fetch must wait
        logic stall_csr;
    } id_cu_t;

    // register read stage status
    typedef struct packed {
        logic stall_csr;
    } rr_cu_t;

    // execute stage status
    typedef struct packed {
        // multi-cycle op busy
        logic stall;
        logic stall_csr;
    } exe_cu_t;

    // writeback stage status
    typedef struct packed {
        logic valid;
        logic change_pc_ena;
        logic branch_taken;
    } wb_cu_t;

    // csr file status
    typedef struct packed {
        // return from trap
        logic csr_eret;
        logic csr_stall;
    } csr_cu_t;

    // control levels sent back to every stage
    typedef struct packed {
        jump_addr_sel_t sel_addr_if;
        logic           flush_if;
        logic           flush_id;
        logic           flush_rr;
        logic           flush_exe;
        logic           flush_wb;
        logic           stall_if;
        logic           stall_id;
        logic           stall_rr;
        logic           stall_exe;
        logic           stall_wb;
    } pipeline_ctrl_t;

    // one valid bit per stage, bit 0 is if, bit 4 is wb
    typedef logic [4:0] stage_valid_t;

endpackage

// ==== rtl/control_unit.sv ====
// control unit: combinational next-pc, jump source, flush and stall decisions from stage status
`timescale 1ns/1ps

module control_unit import pipe_ctrl_pkg::*; (
    // clock and reset unused, kept so all pipeline blocks share a port list
    input  logic           clk_i,
    input  logic           reset_i,

    input  logic           valid_fetch_i,
    input  id_cu_t         id_cu_i,
    input  rr_cu_t         rr_cu_i,
    input  exe_cu_t        exe_cu_i,
    input  wb_cu_t         wb_cu_i,
    input  csr_cu_t        csr_cu_i,

    output pipeline_ctrl_t pipeline_ctrl_o,
    output next_pc_sel_t   next_pc_o
);

    logic           jump_enable;
    // csr op somewhere between decode and execute
    logic           any_stall_csr;
    // taken branch retiring at writeback
    logic           wb_taken;
    jump_addr_sel_t sel_addr;
    // flush and stall levels, order is {if, id, rr, exe, wb}
    logic [4:0]     flush_vec;
    logic [4:0]     stall_vec;

    assign any_stall_csr = id_cu_i.stall_csr | rr_cu_i.stall_csr | exe_cu_i.stall_csr;
    assign wb_taken      = wb_cu_i.branch_taken & wb_cu_i.valid;

    // jump enable and next pc
    always_comb begin
        jump_enable = (wb_cu_i.valid &&
                       wb_cu_i.change_pc_ena &&
                       wb_cu_i.branch_taken) || id_cu_i.valid_jal;
        // a jump wins over any hold
        if (jump_enable) begin
            next_pc_o = NEXT_PC_SEL_JUMP;
        end else if (!valid_fetch_i || stall_vec[4] || any_stall_csr) begin
            // stall_vec[4] is stall_if from the stall block below
            next_pc_o = NEXT_PC_SEL_PC;
        end else begin
            next_pc_o = NEXT_PC_SEL_PC_4;
        end
    end

    // jump source for fetch
    always_comb begin
        if (csr_cu_i.csr_eret) begin
            // trap return beats a branch at wb
            sel_addr = SEL_JUMP_CSR;
        end else if (wb_taken) begin
            sel_addr = SEL_JUMP_COMMIT;
        end else begin
            sel_addr = SEL_JUMP_DECODE;
        end
    end

    // flushes
    always_comb begin
        if (wb_taken) begin
            // wrong path in if through exe
            flush_vec = 5'b11110;
        end else if (any_stall_csr) begin
            // drop the fetched instruction only
            flush_vec = 5'b10000;
        end else if (id_cu_i.valid_jal) begin
            // instruction behind the jal is dead
            flush_vec = 5'b10000;
        end else begin
            flush_vec = 5'b00000;
        end
    end

    // stalls
    always_comb begin
        if (csr_cu_i.csr_stall || exe_cu_i.stall) begin
            // freeze if through exe, wb keeps draining
            stall_vec = 5'b11110;
        end else begin
            stall_vec = 5'b00000;
        end
    end

    // pack the levels into the control struct
    assign pipeline_ctrl_o.sel_addr_if = sel_addr;
    assign pipeline_ctrl_o.flush_if    = flush_vec[4];
    assign pipeline_ctrl_o.flush_id    = flush_vec[3];
    assign pipeline_ctrl_o.flush_rr    = flush_vec[2];
    assign pipeline_ctrl_o.flush_exe   = flush_vec[1];
    assign pipeline_ctrl_o.flush_wb    = flush_vec[0];
    assign pipeline_ctrl_o.stall_if    = stall_vec[4];
    assign pipeline_ctrl_o.stall_id    = stall_vec[3];
    assign pipeline_ctrl_o.stall_rr    = stall_vec[2];
    assign pipeline_ctrl_o.stall_exe   = stall_vec[1];
    assign pipeline_ctrl_o.stall_wb    = stall_vec[0];

endmodule

// ==== rtl/pc_gen.sv ====
// pc generator: fetch program counter with hold, +4 and jump-target update
`timescale 1ns/1ps

module pc_gen import pipe_ctrl_pkg::*; #(
    // address loaded on reset
    parameter addr_t RESET_PC = 40'h00_8000_0000
) (
    input  logic           clk_i,
    input  logic           reset_i,

    input  next_pc_sel_t   next_pc_i,
    input  jump_addr_sel_t sel_addr_i,
    input  addr_t          jump_addr_decode_i,
    input  addr_t          jump_addr_commit_i,
    input  addr_t          jump_addr_csr_i,

    output addr_t          pc_o
);

    addr_t pc_q;
    addr_t pc_d;
    // target picked by the control unit
    addr_t jump_target;

    // jump target mux
    always_comb begin
        case (sel_addr_i)
            SEL_JUMP_COMMIT: jump_target = jump_addr_commit_i;
            SEL_JUMP_CSR:    jump_target = jump_addr_csr_i;
            // decode target also covers the unused code
            default:         jump_target = jump_addr_decode_i;
        endcase
    end

    // next pc value
    always_comb begin
        case (next_pc_i)
            NEXT_PC_SEL_PC_4: pc_d = pc_q + addr_t'(4);
            NEXT_PC_SEL_JUMP: pc_d = jump_target;
            // hold on stall, idle fetch or unused code
            default:          pc_d = pc_q;
        endcase
    end

    // pc register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== rtl/stage_valid_chain.sv ====
// stage valid chain: per-stage valid bits that advance, hold, take bubbles or clear
`timescale 1ns/1ps

module stage_valid_chain import pipe_ctrl_pkg::*; (
    input  logic           clk_i,
    input  logic           reset_i,

    input  logic           valid_fetch_i,
    input  pipeline_ctrl_t pipeline_ctrl_i,

    output stage_valid_t   stage_valid_o
);

    stage_valid_t valid_q;
    stage_valid_t valid_d;
    // per-stage levels, same bit order as the valid vector
    stage_valid_t flush;
    stage_valid_t stall;
    // what each stage would take when free to move
    stage_valid_t source;

    // unpack the control struct, bit 0 is if
    assign flush = {pipeline_ctrl_i.flush_wb,
                    pipeline_ctrl_i.flush_exe,
                    pipeline_ctrl_i.flush_rr,
                    pipeline_ctrl_i.flush_id,
                    pipeline_ctrl_i.flush_if};

    assign stall = {pipeline_ctrl_i.stall_wb,
                    pipeline_ctrl_i.stall_exe,
                    pipeline_ctrl_i.stall_rr,
                    pipeline_ctrl_i.stall_id,
                    pipeline_ctrl_i.stall_if};

    // fetch feeds if, each stage feeds the next
    assign source = {valid_q[3:0], valid_fetch_i};

    // next valid bits
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            if (flush[i]) begin
                valid_d[i] = 1'b0;
            end else if (stall[i]) begin
                // stage frozen, keep what it holds
                valid_d[i] = valid_q[i];
            end else if (i > 0 && stall[(i > 0) ? i - 1 : 0]) begin
                // upstream frozen, nothing arrives
                valid_d[i] = 1'b0;
            end else begin
                valid_d[i] = source[i];
            end
        end
    end

    // valid register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    assign stage_valid_o = valid_q;

endmodule

// ==== rtl/pipe_ctrl_top.sv ====
// pipeline control top: control unit, pc generator and stage valid chain
`timescale 1ns/1ps

module pipe_ctrl_top import pipe_ctrl_pkg::*; #(
    // fetch address after reset
    parameter addr_t RESET_PC = 40'h00_8000_0000
) (
    input  logic           clk_i,
    input  logic           reset_i,

    // stage status levels
    input  logic           valid_fetch_i,
    input  id_cu_t         id_cu_i,
    input  rr_cu_t         rr_cu_i,
    input  exe_cu_t        exe_cu_i,
    input  wb_cu_t         wb_cu_i,
    input  csr_cu_t        csr_cu_i,

    // jump targets from decode, writeback and csr
    input  addr_t          jump_addr_decode_i,
    input  addr_t          jump_addr_commit_i,
    input  addr_t          jump_addr_csr_i,

    output addr_t          pc_o,
    output pipeline_ctrl_t pipeline_ctrl_o,
    output stage_valid_t   stage_valid_o
);

    // control levels, shared by pc_gen and the valid chain
    pipeline_ctrl_t pipeline_ctrl;
    next_pc_sel_t   next_pc;

    // decisions, same cycle
    control_unit control_unit_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .valid_fetch_i   (valid_fetch_i),
        .id_cu_i         (id_cu_i),
        .rr_cu_i         (rr_cu_i),
        .exe_cu_i        (exe_cu_i),
        .wb_cu_i         (wb_cu_i),
        .csr_cu_i        (csr_cu_i),
        .pipeline_ctrl_o (pipeline_ctrl),
        .next_pc_o       (next_pc)
    );

    // fetch pc, one cycle after selection
    pc_gen #(
        .RESET_PC (RESET_PC)
    ) pc_gen_i (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .next_pc_i          (next_pc),
        .sel_addr_i         (pipeline_ctrl.sel_addr_if),
        .jump_addr_decode_i (jump_addr_decode_i),
        .jump_addr_commit_i (jump_addr_commit_i),
        .jump_addr_csr_i    (jump_addr_csr_i),
        .pc_o               (pc_o)
    );

    // live instruction tracking
    stage_valid_chain stage_valid_chain_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .valid_fetch_i   (valid_fetch_i),
        .pipeline_ctrl_i (pipeline_ctrl),
        .stage_valid_o   (stage_valid_o)
    );

    assign pipeline_ctrl_o = pipeline_ctrl;

endmodule

// ==== test/tb_pipe_ctrl.sv ====
// testbench for the pipeline control top: table of stage status rows with expected control and pc
`timescale 1ns/1ps

module tb_pipe_ctrl import pipe_ctrl_pkg::*; ();

    localparam addr_t RESET_PC    = 40'h00_0000_1000;
    localparam int    RESET_CYCLES = 8;
    localparam int    WAIT_LIMIT   = 4;

    // flush and stall patterns, bit order {if, id, rr, exe, wb}
    localparam logic [4:0] FL_NONE  = 5'b00000;
    localparam logic [4:0] FL_IF    = 5'b10000;
    localparam logic [4:0] FL_FRONT = 5'b11110;
    localparam logic [4:0] ST_NONE  = 5'b00000;
    localparam logic [4:0] ST_FRONT = 5'b11110;

    // how the pc moves after a row
    typedef enum logic [2:0] {
        KIND_HOLD,
        KIND_INC,
        KIND_JMP_DECODE,
        KIND_JMP_COMMIT,
        KIND_JMP_CSR
    } pc_kind_t;

    typedef struct packed {
        logic           valid_fetch;
        id_cu_t         id_cu;
        rr_cu_t         rr_cu;
        exe_cu_t        exe_cu;
        wb_cu_t         wb_cu;
        csr_cu_t        csr_cu;
        pipeline_ctrl_t ctrl;
        pc_kind_t       kind;
    } row_t;

    logic           clk_i = 1'b0;
    logic           reset_i;
    logic           valid_fetch_i;
    id_cu_t         id_cu_i;
    rr_cu_t         rr_cu_i;
    exe_cu_t        exe_cu_i;
    wb_cu_t         wb_cu_i;
    csr_cu_t        csr_cu_i;
    addr_t          jump_addr_decode_i;
    addr_t          jump_addr_commit_i;
    addr_t          jump_addr_csr_i;
    addr_t          pc_o;
    pipeline_ctrl_t pipeline_ctrl_o;
    stage_valid_t   stage_valid_o;

    row_t           table_q[$];
    // reference model state
    addr_t          ref_pc;
    stage_valid_t   ref_valid;

    pipe_ctrl_top #(
        .RESET_PC (RESET_PC)
    ) pipe_ctrl_top_i (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .valid_fetch_i      (valid_fetch_i),
        .id_cu_i            (id_cu_i),
        .rr_cu_i            (rr_cu_i),
        .exe_cu_i           (exe_cu_i),
        .wb_cu_i            (wb_cu_i),
        .csr_cu_i           (csr_cu_i),
        .jump_addr_decode_i (jump_addr_decode_i),
        .jump_addr_commit_i (jump_addr_commit_i),
        .jump_addr_csr_i    (jump_addr_csr_i),
        .pc_o               (pc_o),
        .pipeline_ctrl_o    (pipeline_ctrl_o),
        .stage_valid_o      (stage_valid_o)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    function automatic pipeline_ctrl_t make_ctrl(jump_addr_sel_t sel, logic [4:0] fl,
                                                 logic [4:0] st);
        pipeline_ctrl_t c;
        c = '{sel, fl[4], fl[3], fl[2], fl[1], fl[0], st[4], st[3], st[2], st[1], st[0]};
        return c;
    endfunction

    task automatic add_row(logic vf, id_cu_t id, rr_cu_t rr, exe_cu_t exe, wb_cu_t wb,
                           csr_cu_t csr, jump_addr_sel_t sel, logic [4:0] fl,
                           logic [4:0] st, pc_kind_t kind);
        row_t r;
        r = '{vf, id, rr, exe, wb, csr, make_ctrl(sel, fl, st), kind};
        table_q.push_back(r);
    endtask

    function automatic addr_t draw_addr();
        return addr_t'({$urandom, $urandom});
    endfunction

    // chain rule: flush clears, stall holds, stalled upstream gives a bubble, else shift
    function automatic stage_valid_t next_valid(stage_valid_t cur, logic vf, pipeline_ctrl_t c);
        stage_valid_t nxt;
        logic [4:0]   fl;
        logic [4:0]   st;
        logic [4:0]   up;
        fl = {c.flush_wb, c.flush_exe, c.flush_rr, c.flush_id, c.flush_if};
        st = {c.stall_wb, c.stall_exe, c.stall_rr, c.stall_id, c.stall_if};
        up = {cur[3:0], vf};
        for (int i = 0; i < 5; i++) begin
            if (fl[i]) begin
                nxt[i] = 1'b0;
            end else if (st[i]) begin
                nxt[i] = cur[i];
            end else if (i == 0) begin
                nxt[i] = up[0];
            end else if (st[i-1]) begin
                nxt[i] = 1'b0;
            end else begin
                nxt[i] = up[i];
            end
        end
        return nxt;
    endfunction

    task automatic check_ctrl(string name, pipeline_ctrl_t exp, pipeline_ctrl_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_pc(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_valid(string name, stage_valid_t exp, stage_valid_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %b, actual %b", $time, name, exp, act);
            $display("Verification failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic wait_reset_values();
        int guard;
        guard = 0;
        while (!(pc_o === RESET_PC && stage_valid_o === '0)) begin
            if (guard >= WAIT_LIMIT) begin
                $display("Verification failed");
                $fatal(1, "pc and valid bits never reached their reset values");
            end
            @(posedge clk_i);
            guard++;
        end
    endtask

    task automatic apply_row(row_t r);
        valid_fetch_i      = r.valid_fetch;
        id_cu_i            = r.id_cu;
        rr_cu_i            = r.rr_cu;
        exe_cu_i           = r.exe_cu;
        wb_cu_i            = r.wb_cu;
        csr_cu_i           = r.csr_cu;
        jump_addr_decode_i = draw_addr();
        jump_addr_commit_i = draw_addr();
        jump_addr_csr_i    = draw_addr();
    endtask

    function automatic addr_t next_pc(addr_t cur, pc_kind_t kind);
        case (kind)
            KIND_INC:        return cur + 40'd4;
            KIND_JMP_DECODE: return jump_addr_decode_i;
            KIND_JMP_COMMIT: return jump_addr_commit_i;
            KIND_JMP_CSR:    return jump_addr_csr_i;
            default:         return cur;
        endcase
    endfunction

    task automatic build_table();
        // idle after reset
        add_row(0, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_HOLD);
        // steady fetch, fill the pipe
        repeat (5) begin
            add_row(1, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE,
                    KIND_INC);
        end
        // gap at if, so held bits differ from what would shift in
        add_row(0, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_HOLD);
        // exe busy, then csr file busy
        add_row(1, 2'b00, 1'b0, 2'b10, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_FRONT, KIND_HOLD);
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b000, 2'b01, SEL_JUMP_DECODE, FL_NONE, ST_FRONT, KIND_HOLD);
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_INC);
        // stall_csr from id, rr and exe in turn
        add_row(1, 2'b01, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_IF, ST_NONE, KIND_HOLD);
        add_row(1, 2'b00, 1'b1, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_IF, ST_NONE, KIND_HOLD);
        add_row(1, 2'b00, 1'b0, 2'b01, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_IF, ST_NONE, KIND_HOLD);
        // fetch idle
        add_row(0, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_HOLD);
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_INC);
        // taken branch at wb
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b111, 2'b00, SEL_JUMP_COMMIT, FL_FRONT, ST_NONE,
                KIND_JMP_COMMIT);
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_INC);
        // branch taken without change_pc_ena flushes but does not jump
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b101, 2'b00, SEL_JUMP_COMMIT, FL_FRONT, ST_NONE, KIND_INC);
        // decode jal, alone and under an exe stall
        add_row(1, 2'b10, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_IF, ST_NONE,
                KIND_JMP_DECODE);
        add_row(1, 2'b10, 1'b0, 2'b10, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_IF, ST_FRONT,
                KIND_JMP_DECODE);
        // eret over a taken branch, then eret alone
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b111, 2'b10, SEL_JUMP_CSR, FL_FRONT, ST_NONE,
                KIND_JMP_CSR);
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b000, 2'b10, SEL_JUMP_CSR, FL_NONE, ST_NONE, KIND_INC);
        // branch during csr stall, jal with stall_csr
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b111, 2'b01, SEL_JUMP_COMMIT, FL_FRONT, ST_FRONT,
                KIND_JMP_COMMIT);
        add_row(1, 2'b11, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_IF, ST_NONE,
                KIND_JMP_DECODE);
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b100, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_INC);
        add_row(0, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_HOLD);
        add_row(1, 2'b00, 1'b0, 2'b00, 3'b000, 2'b00, SEL_JUMP_DECODE, FL_NONE, ST_NONE, KIND_INC);
    endtask

    initial begin
        void'($urandom(32'hcdeb_3848));
        reset_i            = 1'b1;
        valid_fetch_i      = 1'b0;
        id_cu_i            = '0;
        rr_cu_i            = '0;
        exe_cu_i           = '0;
        wb_cu_i            = '0;
        csr_cu_i           = '0;
        jump_addr_decode_i = '0;
        jump_addr_commit_i = '0;
        jump_addr_csr_i    = '0;
        build_table();

        for (int cyc = 0; cyc < RESET_CYCLES; cyc++) begin
            @(posedge clk_i);
        end
        #2 reset_i = 1'b0;
        wait_reset_values();
        ref_pc    = RESET_PC;
        ref_valid = '0;

        foreach (table_q[n]) begin
            @(posedge clk_i);
            #2;
            // registers settled on the last edge
            check_pc("pc_o", ref_pc, pc_o);
            check_valid("stage_valid_o", ref_valid, stage_valid_o);
            apply_row(table_q[n]);
            @(negedge clk_i);
            check_ctrl("pipeline_ctrl_o", table_q[n].ctrl, pipeline_ctrl_o);
            ref_pc    = next_pc(ref_pc, table_q[n].kind);
            ref_valid = next_valid(ref_valid, table_q[n].valid_fetch, table_q[n].ctrl);
        end

        // last row's effect
        @(posedge clk_i);
        #2;
        check_pc("pc_o", ref_pc, pc_o);
        check_valid("stage_valid_o", ref_valid, stage_valid_o);

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== pipe_ctrl.f ====
rtl/pipe_ctrl_pkg.sv
rtl/control_unit.sv
rtl/pc_gen.sv
rtl/stage_valid_chain.sv
rtl/pipe_ctrl_top.sv
test/tb_pipe_ctrl.sv
